/* sources.f */
rtl/vga_pkg.sv
rtl/vga_frame_fetch.sv
rtl/pixel_fifo.sv
rtl/vga_timing_generator.sv
rtl/vga_controller.sv
dv/vga_controller_assertions.sv
dv/vga_controller_tb.sv

/* Bender.yml */
package:
  name: vga_controller

sources:
  - rtl/vga_pkg.sv
  - rtl/vga_frame_fetch.sv
  - rtl/pixel_fifo.sv
  - rtl/vga_timing_generator.sv
  - rtl/vga_controller.sv
  - target: simulation
    files:
      - dv/vga_controller_assertions.sv
      - dv/vga_controller_tb.sv

/* dv/vga_controller_tb.sv */
`timescale 1ns/1ps

module vga_controller_tb import vga_pkg::*;
();

	// One frame in clk cycles with pixel slots at half the clock rate
	localparam int FRAME_CYCLES = 2 * H_TOTAL * V_TOTAL;
	localparam addr_t NEW_BASE = 32'h2004_0000;
	// Gap cap per burst keeps the FIFO ahead of the display
	localparam int MAX_GAPS = 16;

	logic clk;
	logic reset;
	logic fb_base_update_en;
	addr_t fb_new_base;
	logic arready;
	logic rvalid;
	pixel_t rdata;
	logic arvalid;
	addr_t araddr;
	burst_len_t arlen;
	logic frame_toggle;
	colour_t vga_r;
	colour_t vga_g;
	colour_t vga_b;
	logic vga_clk;
	logic vga_blank_n;
	logic vga_hs;
	logic vga_vs;

	vga_controller dut_i (.*);

	// Checker also sees the internal FIFO flag and frame start pulse
	bind vga_controller vga_controller_assertions assertions_i (.*);

	initial
		clk = 1'b0;

	always
		#4 clk = !clk;

	// Returns 1 ns after a rising edge where inputs change
	task automatic wait_cycles(input int count);
		repeat (count) @(posedge clk);
		#1;
	endtask

	task automatic update_base(input addr_t base);
		fb_base_update_en = 1'b1;
		fb_new_base = base;
		wait_cycles(1);
		fb_base_update_en = 1'b0;
	endtask

	// Serves one read burst with the word index in the RGB bytes
	task automatic serve_burst();
		int unsigned word_index;
		int beat;
		int gaps;
		int delay;
		logic gap_q;
		while (!arvalid)
			wait_cycles(1);
		// Address phase stall of 0 to 3 cycles
		delay = $urandom_range(3, 0);
		if (delay > 0)
			wait_cycles(delay);
		arready = 1'b1;
		word_index = araddr >> 2;
		wait_cycles(1);
		arready = 1'b0;
		beat = 0;
		gaps = 0;
		gap_q = 1'b0;
		while (beat < BURST_LENGTH)
		begin
			// Never two idle cycles in a row
			if (!gap_q && gaps < MAX_GAPS && $urandom_range(3, 0) == 0)
			begin
				rvalid = 1'b0;
				gap_q = 1'b1;
				gaps++;
			end
			else
			begin
				rvalid = 1'b1;
				rdata = {24'(word_index + beat), 8'h00};
				gap_q = 1'b0;
				beat++;
			end
			wait_cycles(1);
		end
		rvalid = 1'b0;
	endtask

	initial
	begin
		void'($urandom(96));
		reset = 1'b1;
		fb_base_update_en = 1'b0;
		fb_new_base = '0;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		wait_cycles(4);
		reset = 1'b0;
		// First frame opens right after reset
		@(posedge frame_toggle);
		wait_cycles(FRAME_CYCLES / 2);
		update_base(NEW_BASE);
		@(frame_toggle);
		@(frame_toggle);
		// Frame start checks fire on the following edge
		wait_cycles(1);
		if (dut_i.assertions_i.failed)
		begin
			$display("TESTBENCH FAILED");
			$fatal(1, "Assertion failures were seen during the run");
		end
		else
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

	// Memory model
	initial
	begin
		@(negedge reset);
		forever
			serve_burst();
	end

	initial
	begin
		wait (dut_i.assertions_i.failed);
		$display("TESTBENCH FAILED");
		$fatal(1, "An assertion in the DUT checker failed");
	end

	// Watchdog allows four frame periods
	initial
	begin
		wait_cycles(4 * FRAME_CYCLES);
		$display("TESTBENCH FAILED");
		$fatal(1, "Timeout, three frame starts were not seen in four frame periods");
	end

endmodule

/* dv/vga_controller_assertions.sv */
`timescale 1ns/1ps

module vga_controller_assertions import vga_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input logic       fb_base_update_en,
	input addr_t      fb_new_base,
	input logic       arvalid,
	input logic       arready,
	input addr_t      araddr,
	input burst_len_t arlen,
	input logic       frame_toggle,
	input colour_t    vga_r,
	input colour_t    vga_g,
	input colour_t    vga_b,
	input logic       vga_clk,
	input logic       vga_blank_n,
	input logic       vga_hs,
	input logic       vga_vs,
	input logic       new_frame,
	input logic       fifo_empty
);

	localparam int BURSTS_PER_FRAME = TOTAL_PIXELS / BURST_LENGTH;

	// Raised by any failing check
	logic failed = 1'b0;

	// Copy of the host base register
	addr_t host_base;
	// Base of the frame now on screen
	addr_t frame_base;
	// Address the next request must carry
	addr_t next_addr;
	int burst_count;
	pixel_count_t vis_count;
	// Clocks since the last hsync fall
	int h_phase;
	// Lines since the last vsync fall
	int v_lines;
	int blank_run;
	int toggles;
	logic toggle_q;
	logic hs_q;
	logic vs_q;
	// Set by the first frame start pulse
	logic started;
	logic frame_seen;
	logic sync_seen;
	logic toggle_edge;
	logic hs_fall;
	logic vs_fall;
	logic pop;
	logic [23:0] exp_colour;

	assign toggle_edge = frame_toggle != toggle_q;
	assign hs_fall = hs_q && !vga_hs;
	assign vs_fall = vs_q && !vga_vs;
	assign pop = vga_clk && vga_blank_n;
	// Word index of this pixel with alpha dropped
	assign exp_colour = 24'((frame_base >> 2) + addr_t'(vis_count));

	function automatic void report_mismatch(input string check, input logic [31:0] expected,
		input logic [31:0] actual);
		failed = 1'b1;
		$error("FAIL %s expected %0h actual %0h", check, expected, actual);
	endfunction

	function automatic void flag_violation(input string what);
		failed = 1'b1;
		$error("%s", what);
	endfunction

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			host_base <= DEFAULT_FB_BASE;
			frame_base <= DEFAULT_FB_BASE;
			next_addr <= DEFAULT_FB_BASE;
			burst_count <= 0;
			vis_count <= '0;
			h_phase <= 0;
			v_lines <= 0;
			blank_run <= 0;
			toggles <= 0;
			toggle_q <= 1'b0;
			hs_q <= 1'b1;
			vs_q <= 1'b1;
			started <= 1'b0;
			frame_seen <= 1'b0;
			sync_seen <= 1'b0;
		end
		else
		begin
			toggle_q <= frame_toggle;
			hs_q <= vga_hs;
			vs_q <= vga_vs;
			if (new_frame)
				started <= 1'b1;
			if (fb_base_update_en)
				host_base <= fb_new_base;
			if (toggle_edge)
			begin
				frame_seen <= 1'b1;
				frame_base <= host_base;
				next_addr <= host_base;
				burst_count <= 0;
			end
			// Next request follows on from an accepted one
			if (arvalid && arready)
			begin
				next_addr <= araddr + addr_t'(BURST_BYTES);
				burst_count <= (toggle_edge ? 0 : burst_count) + 1;
			end
			if (vs_fall)
			begin
				sync_seen <= 1'b1;
				vis_count <= '0;
				v_lines <= 0;
				toggles <= int'(toggle_edge);
			end
			else
			begin
				if (pop)
					vis_count <= vis_count + pixel_count_t'(1);
				if (hs_fall)
					v_lines <= v_lines + 1;
				if (toggle_edge)
					toggles <= toggles + 1;
			end
			h_phase <= hs_fall ? 1 : h_phase + 1;
			blank_run <= vga_blank_n ? blank_run + 1 : 0;
		end
	end

	// Quiet until the first frame starts
	reset_idle: assert property (@(posedge clk) disable iff (reset)
		!started |-> !arvalid && !vga_blank_n && !frame_toggle)
		else flag_violation("Outputs active before the first frame start");

	addr_held: assert property (@(posedge clk) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else flag_violation("arvalid dropped or araddr changed before arready");

	arlen_fixed: assert property (@(posedge clk) disable iff (reset)
		arvalid |-> arlen == burst_len_t'(BURST_LENGTH - 1))
		else report_mismatch("arlen_fixed", BURST_LENGTH - 1, $sampled(arlen));

	first_addr: assert property (@(posedge clk) disable iff (reset)
		toggle_edge |-> arvalid && araddr == host_base)
		else report_mismatch("first_addr", $sampled(host_base), $sampled(araddr));

	next_burst_addr: assert property (@(posedge clk) disable iff (reset)
		arvalid && !toggle_edge |-> araddr == next_addr)
		else report_mismatch("next_burst_addr", $sampled(next_addr), $sampled(araddr));

	bursts_per_frame: assert property (@(posedge clk) disable iff (reset)
		toggle_edge && frame_seen |-> burst_count == BURSTS_PER_FRAME)
		else report_mismatch("bursts_per_frame", BURSTS_PER_FRAME, $sampled(burst_count));

	pixel_data: assert property (@(posedge clk) disable iff (reset)
		pop |-> {vga_r, vga_g, vga_b} == exp_colour)
		else report_mismatch("pixel_data", $sampled(exp_colour),
			$sampled({vga_r, vga_g, vga_b}));

	no_underrun: assert property (@(posedge clk) disable iff (reset)
		pop |-> !fifo_empty)
		else flag_violation("Pixel FIFO empty on a visible pixel slot");

	toggle_per_frame: assert property (@(posedge clk) disable iff (reset)
		vs_fall |-> toggles == 1)
		else report_mismatch("toggle_per_frame", 1, $sampled(toggles));

	// Sync and blanking widths in clk cycles at two per slot
	hsync_period: assert property (@(posedge clk) disable iff (reset)
		hs_fall && sync_seen |-> h_phase == 2 * H_TOTAL)
		else report_mismatch("hsync_period", 2 * H_TOTAL, $sampled(h_phase));

	hsync_width: assert property (@(posedge clk) disable iff (reset)
		$rose(vga_hs) |-> h_phase == 2 * H_SYNC)
		else report_mismatch("hsync_width", 2 * H_SYNC, $sampled(h_phase));

	vsync_period: assert property (@(posedge clk) disable iff (reset)
		vs_fall && sync_seen |-> v_lines == V_TOTAL)
		else report_mismatch("vsync_period", V_TOTAL, $sampled(v_lines));

	vsync_width: assert property (@(posedge clk) disable iff (reset)
		$rose(vga_vs) |-> v_lines == V_SYNC)
		else report_mismatch("vsync_width", V_SYNC, $sampled(v_lines));

	blank_width: assert property (@(posedge clk) disable iff (reset)
		$fell(vga_blank_n) |-> blank_run == 2 * H_VISIBLE)
		else report_mismatch("blank_width", 2 * H_VISIBLE, $sampled(blank_run));

	vga_clk_alternates: assert property (@(posedge clk) disable iff (reset)
		$rose(vga_clk) |=> !vga_clk ##1 $rose(vga_clk))
		else flag_violation("vga_clk did not alternate every clock cycle");

endmodule

/* rtl/vga_controller.sv */
`timescale 1ns/1ps

module vga_controller import vga_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       fb_base_update_en,
	input  addr_t      fb_new_base,
	input  logic       arready,
	input  logic       rvalid,
	input  pixel_t     rdata,
	output logic       arvalid,
	output addr_t      araddr,
	output burst_len_t arlen,
	output logic       frame_toggle,
	output colour_t    vga_r,
	output colour_t    vga_g,
	output colour_t    vga_b,
	output logic       vga_clk,
	output logic       vga_blank_n,
	output logic       vga_hs,
	output logic       vga_vs
);

	logic pixel_enable;
	logic in_visible_region;
	logic new_frame;
	logic fifo_pop;
	logic fifo_empty;
	logic fifo_almost_empty;
	pixel_t pop_data;

	// Memory side, fills the FIFO a burst at a time
	vga_frame_fetch fetch_i (
		.clk               (clk),
		.reset             (reset),
		.fb_base_update_en (fb_base_update_en),
		.fb_new_base       (fb_new_base),
		.new_frame         (new_frame),
		.fifo_almost_empty (fifo_almost_empty),
		.arready           (arready),
		.rvalid            (rvalid),
		.frame_toggle      (frame_toggle),
		.arvalid           (arvalid),
		.araddr            (araddr),
		.arlen             (arlen)
	);

	// Flushed at each frame start, which also recovers from an underrun
	pixel_fifo fifo_i (
		.clk          (clk),
		.reset        (reset),
		.flush        (new_frame),
		.push         (rvalid),
		.push_data    (rdata),
		.pop          (fifo_pop),
		.pop_data     (pop_data),
		.empty        (fifo_empty),
		.almost_empty (fifo_almost_empty)
	);

	vga_timing_generator timing_i (
		.clk               (clk),
		.reset             (reset),
		.pixel_enable      (pixel_enable),
		.in_visible_region (in_visible_region),
		.new_frame         (new_frame),
		.hsync             (vga_hs),
		.vsync             (vga_vs)
	);

	// One pixel consumed per visible slot
	assign fifo_pop = pixel_enable && in_visible_region;

	// Alpha byte is not sent to the DAC
	assign vga_r = pop_data[31:24];
	assign vga_g = pop_data[23:16];
	assign vga_b = pop_data[15:8];

	// Clock enable doubles as the DAC clock
	assign vga_clk = pixel_enable;
	assign vga_blank_n = in_visible_region;

endmodule

/* rtl/vga_timing_generator.sv */
`timescale 1ns/1ps

module vga_timing_generator import vga_pkg::*;
(
	input  logic clk,
	input  logic reset,
	output logic pixel_enable,
	output logic in_visible_region,
	output logic new_frame,
	output logic hsync,
	output logic vsync
);

	// Slot within line, visible area first, then front porch, sync, back porch
	logic [9:0] h_count;

	// Line within frame, same ordering as the horizontal counter
	logic [9:0] v_count;

	logic h_visible;
	logic v_visible;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			pixel_enable <= 1'b0;
			h_count <= '0;
			// Start at the top of vertical blanking so the first slot opens a frame
			v_count <= 10'(V_VISIBLE);
		end
		else
		begin
			// One pixel slot every second clock
			pixel_enable <= !pixel_enable;
			if (pixel_enable)
			begin
				if (h_count == 10'(H_TOTAL - 1))
				begin
					h_count <= '0;
					if (v_count == 10'(V_TOTAL - 1))
						v_count <= '0;
					else
						v_count <= v_count + 10'd1;
				end
				else
					h_count <= h_count + 10'd1;
			end
		end
	end

	assign h_visible = h_count < 10'(H_VISIBLE);
	assign v_visible = v_count < 10'(V_VISIBLE);
	assign in_visible_region = h_visible && v_visible;

	// Syncs are active low
	assign hsync = !(h_count >= 10'(H_VISIBLE + H_FRONT)
		&& h_count < 10'(H_VISIBLE + H_FRONT + H_SYNC));
	assign vsync = !(v_count >= 10'(V_VISIBLE + V_FRONT)
		&& v_count < 10'(V_VISIBLE + V_FRONT + V_SYNC));

	// First slot of the first front porch line, start of vertical blanking
	assign new_frame = pixel_enable && h_count == '0 && v_count == 10'(V_VISIBLE);

endmodule

/* rtl/pixel_fifo.sv */
`timescale 1ns/1ps

module pixel_fifo import vga_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   flush,
	input  logic   push,
	input  pixel_t push_data,
	input  logic   pop,
	output pixel_t pop_data,
	output logic   empty,
	output logic   almost_empty
);

	pixel_t mem [PIXEL_FIFO_DEPTH];

	logic [6:0] wr_ptr;
	logic [6:0] rd_ptr;
	fifo_count_t count;
	fifo_count_t count_next;
	logic do_push;
	logic do_pop;

	// Push on full or pop on empty is dropped
	assign do_push = push && count != fifo_count_t'(PIXEL_FIFO_DEPTH);
	assign do_pop = pop && count != '0;

	always_comb
	begin
		count_next = count;
		if (flush)
			count_next = '0;
		else if (do_push && !do_pop)
			count_next = count + fifo_count_t'(1);
		else if (do_pop && !do_push)
			count_next = count - fifo_count_t'(1);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			almost_empty <= 1'b1;
		end
		else
		begin
			count <= count_next;
			// Registered so the fetch engine sees a clean level
			almost_empty <= count_next <= fifo_count_t'(REFILL_THRESHOLD);
			if (flush)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
			end
			else
			begin
				if (do_push)
					wr_ptr <= wr_ptr + 7'd1;
				if (do_pop)
					rd_ptr <= rd_ptr + 7'd1;
			end
		end
	end

	// Storage only, no reset
	always_ff @(posedge clk)
	begin
		if (do_push && !flush)
			mem[wr_ptr] <= push_data;
	end

	// Head of queue, held while empty
	assign pop_data = mem[rd_ptr];
	assign empty = count == '0;

endmodule

/* rtl/vga_frame_fetch.sv */
`timescale 1ns/1ps

module vga_frame_fetch import vga_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       fb_base_update_en,
	input  addr_t      fb_new_base,
	input  logic       new_frame,
	input  logic       fifo_almost_empty,
	input  logic       arready,
	input  logic       rvalid,
	output logic       frame_toggle,
	output logic       arvalid,
	output addr_t      araddr,
	output burst_len_t arlen
);

	typedef enum logic [1:0] {
		STATE_WAIT_FRAME,
		STATE_WAIT_ROOM,
		STATE_ISSUE_ADDR,
		STATE_BURST
	} fetch_state_t;

	fetch_state_t state;

	// Base used for the next frame, software may rewrite it at any time
	addr_t fb_base;

	// Address of the burst being requested or received
	addr_t fetch_addr;

	// Beats received in the current burst
	burst_len_t beat_count;

	// First pixel index of the current burst
	pixel_count_t pixel_count;

	logic last_beat;
	logic last_burst;

	// Final beat of a burst arrives
	assign last_beat = rvalid && beat_count == burst_len_t'(BURST_LENGTH - 1);

	// Current burst covers the tail of the frame
	assign last_burst = pixel_count == pixel_count_t'(TOTAL_PIXELS - BURST_LENGTH);

	// Base register, a new value is picked up at the next frame start
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			fb_base <= DEFAULT_FB_BASE;
		else if (fb_base_update_en)
			fb_base <= fb_new_base;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= STATE_WAIT_FRAME;
			fetch_addr <= DEFAULT_FB_BASE;
			beat_count <= '0;
			pixel_count <= '0;
			frame_toggle <= 1'b0;
		end
		else
		begin
			unique case (state)
				STATE_WAIT_FRAME:
				begin
					// FIFO is flushed by the same pulse, so room is guaranteed
					if (new_frame)
					begin
						state <= STATE_ISSUE_ADDR;
						fetch_addr <= fb_base;
						pixel_count <= '0;
						frame_toggle <= !frame_toggle;
					end
				end

				STATE_WAIT_ROOM:
				begin
					if (fifo_almost_empty)
						state <= STATE_ISSUE_ADDR;
				end

				STATE_ISSUE_ADDR:
				begin
					// Address phase completes on arready
					if (arready)
					begin
						state <= STATE_BURST;
						beat_count <= '0;
					end
				end

				STATE_BURST:
				begin
					// Data is always accepted, gaps in rvalid stretch the burst
					if (last_beat)
					begin
						beat_count <= '0;
						if (last_burst)
							state <= STATE_WAIT_FRAME;
						else
						begin
							fetch_addr <= fetch_addr + addr_t'(BURST_BYTES);
							pixel_count <= pixel_count + pixel_count_t'(BURST_LENGTH);
							if (fifo_almost_empty)
								state <= STATE_ISSUE_ADDR;
							else
								state <= STATE_WAIT_ROOM;
						end
					end
					else if (rvalid)
						beat_count <= beat_count + burst_len_t'(1);
				end

				default:
					state <= STATE_WAIT_FRAME;
			endcase
		end
	end

	// Request held with a stable address until accepted
	assign arvalid = state == STATE_ISSUE_ADDR;
	assign araddr = fetch_addr;
	assign arlen = burst_len_t'(BURST_LENGTH - 1);

endmodule

/* rtl/vga_pkg.sv */
package vga_pkg;

	// Byte address on the AXI read bus
	typedef logic [31:0] addr_t;

	// RGBA word, red in the top byte, alpha in the bottom byte
	typedef logic [31:0] pixel_t;

	// One DAC colour channel
	typedef logic [7:0] colour_t;

	// AXI burst length field, beats minus one
	typedef logic [7:0] burst_len_t;

	// Pixel index within one frame, up to 640*480
	typedef logic [18:0] pixel_count_t;

	// Pixel FIFO occupancy, 0 to depth inclusive
	typedef logic [7:0] fifo_count_t;

	// Horizontal timing, in pixel slots
	localparam int H_VISIBLE = 640;
	localparam int H_FRONT = 16;
	localparam int H_SYNC = 96;
	localparam int H_BACK = 48;
	localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

	// Vertical timing, in lines
	localparam int V_VISIBLE = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 33;
	localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

	localparam int TOTAL_PIXELS = H_VISIBLE * V_VISIBLE;

	// Fixed read bursts of 32-bit pixels
	localparam int BURST_LENGTH = 64;
	localparam int BURST_BYTES = BURST_LENGTH * 4;

	// FIFO holds two bursts; below the threshold a whole burst fits
	localparam int PIXEL_FIFO_DEPTH = 128;
	localparam int REFILL_THRESHOLD = PIXEL_FIFO_DEPTH - BURST_LENGTH - 1;

	localparam addr_t DEFAULT_FB_BASE = 32'h1000_0000;

endpackage
